// ==== design/tlb_consts.svh ====
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// geometry
`define TLB_WAYS 4
`define TLB_SETS 16
`define TLB_SET_BITS 4
`define TLB_WAY_BITS 2

// field widths
`define TLB_TAG_BITS 20
`define TLB_PPN_BITS 18

// one set cleared per cycle
`define TLB_INIT_CYCLES 16

`endif

// ==== design/tlb_pkg.sv ====
`include "tlb_consts.svh"

package tlb_pkg;

  typedef logic [`TLB_TAG_BITS-1:0] tlb_tag_t;
  typedef logic [`TLB_SET_BITS-1:0] tlb_set_t;
  typedef logic [`TLB_WAY_BITS-1:0] tlb_way_t;

  // translation payload
  typedef struct packed {
    logic [`TLB_PPN_BITS-1:0] ppn;
    logic                     writable;
    logic                     user;
  } tlb_pte_t;

  // one stored word of a way
  typedef struct packed {
    logic     valid;
    tlb_tag_t tag;
    tlb_pte_t pte;
  } tlb_entry_t;

endpackage

// ==== design/tlb_ctrl_pkg.sv ====
package tlb_ctrl_pkg;

  // init sweep, then normal operation
  typedef enum logic {
    ST_INIT,
    ST_RUN
  } tlb_state_e;

  typedef enum logic {
    OP_FILL,
    OP_INVAL
  } tlb_op_e;

endpackage

// ==== design/tlb_if.sv ====
`include "tlb_consts.svh"

// per-way compare results
interface tlb_probe_if;
  import tlb_pkg::*;

  logic     look_hit;
  tlb_pte_t look_pte;
  // write tag found in the write set
  logic     wr_hit;

  modport way (output look_hit, output look_pte, output wr_hit);
  modport resp (input look_hit, input look_pte);
  modport ctrl (input look_hit, input wr_hit);
endinterface

// storage write shared by all ways
interface tlb_wr_if;
  import tlb_pkg::*;

  // one enable bit per way
  logic [`TLB_WAYS-1:0] wen;
  tlb_set_t             set;
  tlb_entry_t           entry;

  modport ctrl (output wen, output set, output entry);
  modport way (input wen, input set, input entry);
endinterface

// ==== design/tlb_way.sv ====
`include "tlb_consts.svh"

module tlb_way (
  input  logic              clk,
  input  tlb_pkg::tlb_set_t lookup_set,
  input  tlb_pkg::tlb_tag_t lookup_tag,
  input  tlb_pkg::tlb_tag_t wr_tag,
  input  tlb_pkg::tlb_set_t wr_set,
  tlb_wr_if.way             wr,
  input  logic              wen,
  tlb_probe_if.way          probe
);
  import tlb_pkg::*;

  tlb_entry_t mem [`TLB_SETS];
  tlb_entry_t look_rd;
  tlb_entry_t wr_rd;

  // two async read ports
  assign look_rd = mem[lookup_set];
  assign wr_rd   = mem[wr_set];

  // lookup side
  assign probe.look_hit = look_rd.valid && (look_rd.tag == lookup_tag);
  assign probe.look_pte = look_rd.pte;

  // write side, used to find an existing copy of the tag
  assign probe.wr_hit = wr_rd.valid && (wr_rd.tag == wr_tag);

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[wr.set] <= wr.entry;
    end
  end

endmodule

// ==== design/tlb_lru.sv ====
`include "tlb_consts.svh"

module tlb_lru (
  input  logic              clk,
  input  logic              touch,
  input  tlb_pkg::tlb_set_t touch_set,
  input  tlb_pkg::tlb_way_t touch_way,
  input  logic              init,
  input  tlb_pkg::tlb_set_t victim_set,
  output tlb_pkg::tlb_way_t victim
);
  import tlb_pkg::*;

  typedef logic [`TLB_WAY_BITS-1:0] age_t;

  // ages per set, highest is most recently used
  age_t [`TLB_WAYS-1:0] ages [`TLB_SETS];
  age_t [`TLB_WAYS-1:0] cur;
  age_t [`TLB_WAYS-1:0] next;
  age_t                 old_age;

  assign cur     = ages[touch_set];
  assign old_age = cur[touch_way];

  always_comb begin
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (init) begin
        next[w] = age_t'(w);
      end else if (tlb_way_t'(w) == touch_way) begin
        next[w] = age_t'(`TLB_WAYS - 1);
      end else if (cur[w] > old_age) begin
        // younger ways slide down one slot
        next[w] = cur[w] - 1'b1;
      end else begin
        next[w] = cur[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (init || touch) begin
      ages[touch_set] <= next;
    end
  end

  // ages of a set are a permutation, so exactly one way is at zero
  always_comb begin
    victim = '0;
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (ages[victim_set][w] == '0) begin
        victim = tlb_way_t'(w);
      end
    end
  end

endmodule

// ==== design/tlb_ctrl.sv ====
`include "tlb_consts.svh"

module tlb_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup_valid,
  input  tlb_pkg::tlb_set_t     lookup_set,
  input  logic                  wr_valid,
  input  tlb_ctrl_pkg::tlb_op_e wr_op,
  input  tlb_pkg::tlb_set_t     wr_set,
  input  tlb_pkg::tlb_tag_t     wr_tag,
  input  tlb_pkg::tlb_pte_t     wr_pte,
  tlb_probe_if.ctrl             probe [`TLB_WAYS],
  tlb_wr_if.ctrl                wr,
  input  tlb_pkg::tlb_way_t     victim,
  output logic                  lookup_accept,
  output logic                  lru_touch,
  output tlb_pkg::tlb_set_t     lru_set,
  output tlb_pkg::tlb_way_t     lru_way,
  output logic                  lru_init,
  output logic                  ready
);
  import tlb_pkg::*;
  import tlb_ctrl_pkg::*;

  tlb_state_e           state;
  tlb_set_t             init_cnt;
  logic [`TLB_WAYS-1:0] look_hit_vec;
  logic [`TLB_WAYS-1:0] wr_hit_vec;
  tlb_way_t             look_way;
  tlb_way_t             wr_hit_way;
  tlb_way_t             target;
  logic                 init;
  logic                 wr_accept;
  logic                 fill;
  logic                 wr_do;

  function automatic tlb_way_t encode(input logic [`TLB_WAYS-1:0] vec);
    tlb_way_t way;
    way = '0;
    for (int i = 0; i < `TLB_WAYS; i++) begin
      if (vec[i]) begin
        way = tlb_way_t'(i);
      end
    end
    return way;
  endfunction

  for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_probe
    assign look_hit_vec[w] = probe[w].look_hit;
    assign wr_hit_vec[w]   = probe[w].wr_hit;
  end

  // init sweep over all sets after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_INIT;
      init_cnt <= '0;
    end else if (state == ST_INIT) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == tlb_set_t'(`TLB_INIT_CYCLES - 1)) begin
        state <= ST_RUN;
      end
    end
  end

  assign init          = (state == ST_INIT);
  assign ready         = (state == ST_RUN);
  assign lookup_accept = lookup_valid && ready;
  assign wr_accept     = wr_valid && ready;
  assign fill          = wr_accept && (wr_op == OP_FILL);

  // existing copy of the tag wins over the LRU victim
  assign look_way   = encode(look_hit_vec);
  assign wr_hit_way = encode(wr_hit_vec);
  assign target     = (|wr_hit_vec) ? wr_hit_way : victim;

  // invalidate of an absent tag writes nothing
  assign wr_do = fill || (wr_accept && (|wr_hit_vec));

  assign wr.wen = init ? '1 :
                  wr_do ? ({{(`TLB_WAYS - 1){1'b0}}, 1'b1} << target) : '0;
  assign wr.set   = init ? init_cnt : wr_set;
  assign wr.entry = init ? '0 : tlb_entry_t'{valid: fill, tag: wr_tag, pte: wr_pte};

  // a write in the same cycle owns the LRU update
  assign lru_init  = init;
  assign lru_touch = fill || (lookup_accept && (|look_hit_vec) && !wr_accept);
  assign lru_set   = init ? init_cnt : (wr_accept ? wr_set : lookup_set);
  assign lru_way   = wr_accept ? target : look_way;

endmodule

// ==== design/tlb_resp.sv ====
`include "tlb_consts.svh"

module tlb_resp (
  input  logic              clk,
  input  logic              rst,
  input  logic              accept,
  tlb_probe_if.resp         probe [`TLB_WAYS],
  output logic              resp_valid,
  output logic              resp_hit,
  output tlb_pkg::tlb_way_t resp_way,
  output tlb_pkg::tlb_pte_t resp_pte
);
  import tlb_pkg::*;

  logic [`TLB_WAYS-1:0] hit_vec;
  tlb_pte_t             pte_arr [`TLB_WAYS];
  tlb_way_t             hit_way;
  tlb_pte_t             hit_pte;

  for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_probe
    assign hit_vec[w] = probe[w].look_hit;
    assign pte_arr[w] = probe[w].look_pte;
  end

  // and-or select, hits are one-hot so a miss leaves zeros
  always_comb begin
    hit_way = '0;
    hit_pte = '0;
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way = hit_way | tlb_way_t'(w);
        hit_pte = hit_pte | pte_arr[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
    end else begin
      resp_valid <= accept;
      resp_hit   <= accept && (|hit_vec);
    end
  end

  // payload held between responses
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_way <= hit_way;
      resp_pte <= hit_pte;
    end
  end

endmodule

// ==== design/dtlb_top.sv ====
`include "tlb_consts.svh"

module dtlb_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup_valid,
  input  tlb_pkg::tlb_set_t     lookup_set,
  input  tlb_pkg::tlb_tag_t     lookup_tag,
  input  logic                  wr_valid,
  input  tlb_ctrl_pkg::tlb_op_e wr_op,
  input  tlb_pkg::tlb_set_t     wr_set,
  input  tlb_pkg::tlb_tag_t     wr_tag,
  input  tlb_pkg::tlb_pte_t     wr_pte,
  output logic                  ready,
  output logic                  resp_valid,
  output logic                  resp_hit,
  output tlb_pkg::tlb_way_t     resp_way,
  output tlb_pkg::tlb_pte_t     resp_pte
);
  import tlb_pkg::*;

  tlb_way_t             victim;
  logic                 lookup_accept;
  logic                 lru_touch;
  tlb_set_t             lru_set;
  tlb_way_t             lru_way;
  logic                 lru_init;
  // lookup hits of all ways, watched by the assertions
  logic [`TLB_WAYS-1:0] look_hit_vec;

  tlb_probe_if probe_if [`TLB_WAYS] ();
  tlb_wr_if    wr_if ();

  for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
    tlb_way u_way (
      .clk        (clk),
      .lookup_set (lookup_set),
      .lookup_tag (lookup_tag),
      .wr_tag     (wr_tag),
      .wr_set     (wr_set),
      .wr         (wr_if),
      .wen        (wr_if.wen[w]),
      .probe      (probe_if[w])
    );
    assign look_hit_vec[w] = probe_if[w].look_hit;
  end

  tlb_lru u_lru (
    .clk        (clk),
    .touch      (lru_touch),
    .touch_set  (lru_set),
    .touch_way  (lru_way),
    .init       (lru_init),
    .victim_set (wr_set),
    .victim     (victim)
  );

  tlb_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .lookup_valid  (lookup_valid),
    .lookup_set    (lookup_set),
    .wr_valid      (wr_valid),
    .wr_op         (wr_op),
    .wr_set        (wr_set),
    .wr_tag        (wr_tag),
    .wr_pte        (wr_pte),
    .probe         (probe_if),
    .wr            (wr_if),
    .victim        (victim),
    .lookup_accept (lookup_accept),
    .lru_touch     (lru_touch),
    .lru_set       (lru_set),
    .lru_way       (lru_way),
    .lru_init      (lru_init),
    .ready         (ready)
  );

  tlb_resp u_resp (
    .clk        (clk),
    .rst        (rst),
    .accept     (lookup_accept),
    .probe      (probe_if),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_way   (resp_way),
    .resp_pte   (resp_pte)
  );

endmodule

// ==== verification/dtlb_sva.sv ====
`include "tlb_consts.svh"

module dtlb_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 ready,
  input logic                 resp_valid,
  input logic                 resp_hit,
  input logic [`TLB_WAYS-1:0] look_hit_vec
);
  timeunit 1ns;
  timeprecision 1ps;

  hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
    resp_hit |-> resp_valid)
    else $error("resp_hit high without resp_valid");

  no_resp_before_ready: assert property (@(posedge clk) disable iff (rst)
    resp_valid |-> ready)
    else $error("response while ready is low");

  // storage is unknown until the sweep is done
  one_way_hits: assert property (@(posedge clk) disable iff (rst || !ready)
    $onehot0(look_hit_vec))
    else $error("more than one way hit the lookup tag");

endmodule

bind dtlb_top dtlb_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .ready        (ready),
  .resp_valid   (resp_valid),
  .resp_hit     (resp_hit),
  .look_hit_vec (look_hit_vec)
);

// ==== verification/dtlb_tb.sv ====
`include "tlb_consts.svh"

module dtlb_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tlb_pkg::*;
  import tlb_ctrl_pkg::*;

  // the tests take about 1000 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic     clk = 1'b0;
  logic     rst;
  logic     lookup_valid;
  tlb_set_t lookup_set;
  tlb_tag_t lookup_tag;
  logic     wr_valid;
  tlb_op_e  wr_op;
  tlb_set_t wr_set;
  tlb_tag_t wr_tag;
  tlb_pte_t wr_pte;
  logic     ready;
  logic     resp_valid;
  logic     resp_hit;
  tlb_way_t resp_way;
  tlb_pte_t resp_pte;

  // reference model of the entries and ages
  logic     m_valid [`TLB_SETS][`TLB_WAYS];
  tlb_tag_t m_tag [`TLB_SETS][`TLB_WAYS];
  tlb_pte_t m_pte [`TLB_SETS][`TLB_WAYS];
  int       m_age [`TLB_SETS][`TLB_WAYS];

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'd11;

  dtlb_top u_dtlb_top (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // state right after the init sweep
  function automatic void model_init();
    for (int s = 0; s < `TLB_SETS; s++) begin
      for (int w = 0; w < `TLB_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_age[s][w]   = w;
      end
    end
  endfunction

  function automatic int model_find(input tlb_set_t s, input tlb_tag_t t);
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        return w;
      end
    end
    return -1;
  endfunction

  function automatic int model_victim(input tlb_set_t s);
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (m_age[s][w] == 0) begin
        return w;
      end
    end
    return 0;
  endfunction

  // touched way goes to the top and ways above its old age drop by one
  function automatic void model_touch(input tlb_set_t s, input int way);
    int old;
    old = m_age[s][way];
    for (int w = 0; w < `TLB_WAYS; w++) begin
      if (m_age[s][w] > old) begin
        m_age[s][w]--;
      end
    end
    m_age[s][way] = `TLB_WAYS - 1;
  endfunction

  task automatic check_hit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_way(input string name, input tlb_way_t exp, input tlb_way_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_pte(input string name, input tlb_pte_t exp, input tlb_pte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic do_write(input tlb_op_e op, input tlb_set_t s, input tlb_tag_t t,
                          input tlb_pte_t p);
    int way;
    @(posedge clk);
    wr_valid <= 1'b1;
    wr_op    <= op;
    wr_set   <= s;
    wr_tag   <= t;
    wr_pte   <= p;
    @(posedge clk);
    wr_valid <= 1'b0;
    way = model_find(s, t);
    if (op == OP_FILL) begin
      if (way < 0) begin
        way = model_victim(s);
      end
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = t;
      m_pte[s][way]   = p;
      model_touch(s, way);
    end else if (way >= 0) begin
      m_valid[s][way] = 1'b0;
    end
  endtask

  task automatic do_lookup(input tlb_set_t s, input tlb_tag_t t, output tlb_way_t got_way);
    int       way;
    tlb_way_t exp_way;
    tlb_pte_t exp_pte;
    @(posedge clk);
    lookup_valid <= 1'b1;
    lookup_set   <= s;
    lookup_tag   <= t;
    @(posedge clk);
    lookup_valid <= 1'b0;
    // response is due in the cycle after the request is taken
    @(negedge clk);
    if (resp_valid !== 1'b1) begin
      errors++;
      $display("no response one cycle after the lookup of set %0d at %0t", s, $time);
    end else begin
      way = model_find(s, t);
      exp_way = '0;
      exp_pte = '0;
      if (way >= 0) begin
        exp_way = tlb_way_t'(way);
        exp_pte = m_pte[s][way];
        model_touch(s, way);
      end
      check_hit("resp_hit", way >= 0, resp_hit);
      check_way("resp_way", exp_way, resp_way);
      check_pte("resp_pte", exp_pte, resp_pte);
    end
    got_way = resp_way;
    // one response per request
    @(negedge clk);
    check_hit("resp_valid", 1'b0, resp_valid);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset();
    int       e;
    tlb_way_t w;
    e = errors;
    // requests during the sweep must be ignored
    @(posedge clk);
    lookup_valid <= 1'b1;
    lookup_set   <= '0;
    lookup_tag   <= 20'h0abc0;
    wr_valid     <= 1'b1;
    wr_op        <= OP_FILL;
    wr_set       <= '0;
    wr_tag       <= 20'h0abc0;
    wr_pte       <= tlb_pte_t'(20'h12345);
    @(posedge clk);
    lookup_valid <= 1'b0;
    wr_valid     <= 1'b0;
    @(negedge clk);
    check_hit("ready", 1'b0, ready);
    while (!ready) begin
      check_hit("resp_valid", 1'b0, resp_valid);
      @(negedge clk);
    end
    for (int s = 0; s < `TLB_SETS; s++) begin
      do_lookup(tlb_set_t'(s), tlb_tag_t'(20'h0abc0 + s), w);
    end
    report_test("reset", e);
  endtask

  // initial ages put fills into ways 0..3 in order
  task automatic test_fill();
    int       e;
    tlb_way_t w;
    e = errors;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift(rng);
      do_write(OP_FILL, 4'd2, tlb_tag_t'(20'h01000 + i), tlb_pte_t'(rng[19:0]));
    end
    for (int i = 0; i < 4; i++) begin
      do_lookup(4'd2, tlb_tag_t'(20'h01000 + i), w);
      check_way("resp_way", tlb_way_t'(i), w);
    end
    report_test("fill", e);
  endtask

  task automatic test_overwrite();
    int       e;
    tlb_way_t w;
    e = errors;
    do_write(OP_FILL, 4'd2, 20'h01001, tlb_pte_t'(20'h5a5a5));
    do_lookup(4'd2, 20'h01001, w);
    check_way("resp_way", 2'd1, w);
    report_test("overwrite", e);
  endtask

  task automatic test_replace();
    int       e;
    tlb_way_t w;
    e = errors;
    for (int i = 0; i < 4; i++) begin
      do_write(OP_FILL, 4'd5, tlb_tag_t'(20'h02000 + i), tlb_pte_t'(20'h10000 + i));
    end
    do_lookup(4'd5, 20'h02000, w);
    do_write(OP_FILL, 4'd5, 20'h02004, tlb_pte_t'(20'h10004));
    // second tag was least recently used
    do_lookup(4'd5, 20'h02004, w);
    check_way("resp_way", 2'd1, w);
    for (int i = 0; i < 4; i++) begin
      do_lookup(4'd5, tlb_tag_t'(20'h02000 + i), w);
    end
    report_test("replace", e);
  endtask

  task automatic test_inval();
    int       e;
    tlb_way_t w;
    e = errors;
    do_write(OP_INVAL, 4'd2, 20'h01002, '0);
    do_lookup(4'd2, 20'h01002, w);
    do_lookup(4'd2, 20'h01000, w);
    check_way("resp_way", 2'd0, w);
    do_lookup(4'd2, 20'h01001, w);
    check_way("resp_way", 2'd1, w);
    do_lookup(4'd2, 20'h01003, w);
    check_way("resp_way", 2'd3, w);
    report_test("invalidate", e);
  endtask

  // half of the operations are lookups over 4 sets and 8 tags
  task automatic test_random();
    int       e;
    tlb_way_t w;
    tlb_set_t s;
    tlb_tag_t t;
    e = errors;
    for (int n = 0; n < 200; n++) begin
      rng = xorshift(rng);
      s = tlb_set_t'(8 + rng[1:0]);
      t = tlb_tag_t'(20'h03000 + rng[4:2]);
      case (rng[6:5])
        2'd0: do_write(OP_FILL, s, t, tlb_pte_t'(rng[31:12]));
        2'd1: do_write(OP_INVAL, s, t, tlb_pte_t'(rng[31:12]));
        default: do_lookup(s, t, w);
      endcase
    end
    report_test("random", e);
  endtask

  initial begin
    rst          = 1'b1;
    lookup_valid = 1'b0;
    lookup_set   = '0;
    lookup_tag   = '0;
    wr_valid     = 1'b0;
    wr_op        = OP_FILL;
    wr_set       = '0;
    wr_tag       = '0;
    wr_pte       = '0;
    model_init();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_fill();
    test_overwrite();
    test_replace();
    test_inval();
    test_random();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/tlb_pkg.sv
design/tlb_ctrl_pkg.sv
design/tlb_if.sv
design/tlb_way.sv
design/tlb_lru.sv
design/tlb_ctrl.sv
design/tlb_resp.sv
design/dtlb_top.sv
verification/dtlb_sva.sv
verification/dtlb_tb.sv
